// ==== project.f ====
+incdir+verilog
verilog/axis_pkg.sv
verilog/csr_pkg.sv
verilog/axis_out_pipe.sv
verilog/axis_probe.sv
verilog/axis_drop.sv
verilog/pkt_drop_top.sv
tests/pkt_drop_sva.sv
tests/pkt_drop_checker.sv
tests/pkt_drop_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the packet drop testbench with Verilator.
# The exit status is zero only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module pkt_drop_tb -f project.f
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vpkt_drop_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
   exit 0
else
   echo "pass message not found"
   exit 1
fi

// ==== tests/pkt_drop_checker.sv ====
/*
 * reference model for the packet drop stage.
 * tracks the drop rule, expected egress beats and drop counters,
 * and compares them with the egress stream and register reads.
 */

`timescale 1ns/1ps

`include "pkt_drop_config.svh"

module pkt_drop_checker
   import csr_pkg::*;
(
   input  logic                         axi4s_in,
   input  logic                         rst,
   input  logic                         s_tvalid,
   input  logic                         s_tready,
   input  logic [`PKT_DATA_BYTES*8-1:0] s_tdata,
   input  logic [`PKT_DATA_BYTES-1:0]   s_tkeep,
   input  logic                         s_tlast,
   input  logic [7:0]                   s_tuser,
   input  logic                         m_tvalid,
   input  logic                         m_tready,
   input  logic [`PKT_DATA_BYTES*8-1:0] m_tdata,
   input  logic [`PKT_DATA_BYTES-1:0]   m_tkeep,
   input  logic                         m_tlast,
   input  logic [7:0]                   m_tuser,
   input  logic                         drop_pkt,
   input  logic                         wb_cyc,
   input  logic                         wb_stb,
   input  logic                         wb_we,
   input  logic [`WB_ADR_WID-1:0]       wb_adr,
   input  logic [`WB_DAT_WID-1:0]       wb_dat_w,
   input  logic [`WB_DAT_WID-1:0]       wb_dat_r,
   input  logic                         wb_ack,
   output int                           stream_errs,
   output int                           reg_errs,
   output int                           pending
);

   localparam int BEAT_W = `PKT_DATA_BYTES * 9 + 9;

   logic [BEAT_W-1:0]      exp_q[$];
   logic [BEAT_W-1:0]      want;
   logic [BEAT_W-1:0]      got;
   logic                   latch_m;
   logic                   dropping;
   logic                   clr;
   logic                   rd_pend;
   logic                   rd_we;
   logic                   ack_d;
   logic [`WB_DAT_WID-1:0] rd_exp;
   logic [`PKT_CNT_WID-1:0] pkts_m;
   logic [`PKT_CNT_WID-1:0] bytes_m;

   initial begin
      stream_errs = 0;
      reg_errs    = 0;
      pending     = 0;
   end

   always @(posedge axi4s_in) begin
      if (rst) begin
         exp_q.delete();
         latch_m = 1'b0;
         rd_pend = 1'b0;
         ack_d   = 1'b0;
         pkts_m  = '0;
         bytes_m = '0;
      end else begin
         dropping = drop_pkt || latch_m;

         // ----------------------------------------
         // egress stream
         // ----------------------------------------
         if (m_tvalid && m_tready) begin
            got = {m_tdata, m_tkeep, m_tlast, m_tuser};
            if (exp_q.size() == 0) begin
               $display("FAILED %0t: egress beat %h with no beat expected", $time, got);
               stream_errs++;
            end else begin
               want = exp_q.pop_front();
               if (got !== want) begin
                  $display("FAILED %0t: egress beat %h, expected %h", $time, got, want);
                  stream_errs++;
               end
            end
         end
         if (s_tvalid && dropping && !s_tready) begin
            $display("FAILED %0t: beat being dropped was not accepted", $time);
            stream_errs++;
         end

         // ----------------------------------------
         // wishbone response and request
         // ----------------------------------------
         if (wb_ack) begin
            if (ack_d || !rd_pend) begin
               $display("FAILED %0t: wishbone ack without a pending request", $time);
               reg_errs++;
            end else if (!rd_we && wb_dat_r !== rd_exp) begin
               $display("FAILED %0t: read data %h, expected %h", $time, wb_dat_r, rd_exp);
               reg_errs++;
            end
            rd_pend = 1'b0;
         end
         ack_d = wb_ack;

         // counters as they stand at the request edge.
         clr = 1'b0;
         if (wb_cyc && wb_stb && !wb_ack) begin
            rd_pend = 1'b1;
            rd_we   = wb_we;
            case (wb_adr)
               DROP_PKTS:  rd_exp = pkts_m;
               DROP_BYTES: rd_exp = bytes_m;
               default:    rd_exp = '0;
            endcase
            clr = wb_we && (wb_adr == DROP_CTRL) && wb_dat_w[0];
         end

         // ----------------------------------------
         // ingress and drop rule
         // ----------------------------------------
         if (s_tvalid && s_tready) begin
            if (!dropping) begin
               exp_q.push_back({s_tdata, s_tkeep, s_tlast, s_tuser});
            end else begin
               bytes_m = bytes_m + $countones(s_tkeep);
               if (s_tlast) begin
                  pkts_m = pkts_m + 1;
               end
            end
         end
         if (s_tvalid && s_tready && s_tlast) begin
            latch_m = 1'b0;
         end else if (drop_pkt) begin
            latch_m = 1'b1;
         end
         // a beat dropped at the clear edge is not counted.
         if (clr) begin
            pkts_m  = '0;
            bytes_m = '0;
         end
         pending = exp_q.size();
      end
   end

endmodule

// ==== tests/pkt_drop_sva.sv ====
/*
 * protocol assertions for the packet drop top level.
 * egress hold under stall, single cycle ack, egress idle in reset.
 */

`timescale 1ns/1ps

`include "pkt_drop_config.svh"

module pkt_drop_sva (
   input logic                        axi4s_in,
   input logic                        rst,
   input logic                        m_tvalid,
   input logic                        m_tready,
   input logic [`PKT_DATA_BYTES*8-1:0] m_tdata,
   input logic [`PKT_DATA_BYTES-1:0]   m_tkeep,
   input logic                        m_tlast,
   input logic [7:0]                  m_tuser,
   input logic                        wb_ack
);

   int fail_count = 0;

   // a stalled egress beat stays put until it is taken.
   hold_stalled: assert property (@(posedge axi4s_in) disable iff (rst)
      m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep)
         && $stable(m_tlast) && $stable(m_tuser))
   else begin
      $error("egress beat changed or vanished while stalled");
      fail_count++;
   end

   ack_single: assert property (@(posedge axi4s_in) disable iff (rst)
      wb_ack |=> !wb_ack)
   else begin
      $error("wishbone ack held for more than one cycle");
      fail_count++;
   end

   valid_in_reset: assert property (@(posedge axi4s_in) rst |=> !m_tvalid)
   else begin
      $error("egress valid high during reset");
      fail_count++;
   end

endmodule

bind pkt_drop_top pkt_drop_sva u_sva (
   .axi4s_in (axi4s_in),
   .rst      (rst),
   .m_tvalid (m_tvalid),
   .m_tready (m_tready),
   .m_tdata  (m_tdata),
   .m_tkeep  (m_tkeep),
   .m_tlast  (m_tlast),
   .m_tuser  (m_tuser),
   .wb_ack   (wb_ack)
);

// ==== tests/pkt_drop_tb.sv ====
/*
 * testbench for the packet drop subsystem.
 * random packets, drop pulses and sink stalls from a fixed seed,
 * plus Wishbone reads and clears of the drop counters.
 */

`timescale 1ns/1ps

`include "pkt_drop_config.svh"

module pkt_drop_tb
   import csr_pkg::*;
;

   localparam int CLK_PERIOD = 100;
   localparam int WAIT_LIMIT = 200;

   logic                         axi4s_in;
   logic                         rst;
   logic                         s_tvalid;
   logic                         s_tready;
   logic [`PKT_DATA_BYTES*8-1:0] s_tdata;
   logic [`PKT_DATA_BYTES-1:0]   s_tkeep;
   logic                         s_tlast;
   logic [7:0]                   s_tuser;
   logic                         m_tvalid;
   logic                         m_tready;
   logic [`PKT_DATA_BYTES*8-1:0] m_tdata;
   logic [`PKT_DATA_BYTES-1:0]   m_tkeep;
   logic                         m_tlast;
   logic [7:0]                   m_tuser;
   logic                         drop_pkt;
   logic                         wb_cyc;
   logic                         wb_stb;
   logic                         wb_we;
   logic [`WB_ADR_WID-1:0]       wb_adr;
   logic [`WB_DAT_WID-1:0]       wb_dat_w;
   logic [`WB_DAT_WID-1:0]       wb_dat_r;
   logic                         wb_ack;

   int stream_errs;
   int reg_errs;
   int pending;
   int timeouts;
   int drop_pct;
   int ready_pct;
   int total;

   initial axi4s_in = 1'b0;
   always #(CLK_PERIOD / 2) axi4s_in = ~axi4s_in;

   pkt_drop_top DUT (.*);

   pkt_drop_checker u_checker (.*);

   // advance to the next falling edge and redraw the sink and drop inputs.
   task automatic next_cycle();
      @(negedge axi4s_in);
      m_tready = ($urandom_range(99, 0) < ready_pct);
      drop_pkt = ($urandom_range(99, 0) < drop_pct);
   endtask

   task automatic send_packet();
      int nbeats;
      int gap;
      int t;
      logic took;
      logic [31:0] rnd;
      nbeats = $urandom_range(6, 1);
      for (int b = 0; b < nbeats; b++) begin
         rnd      = $urandom;
         s_tvalid = 1'b1;
         s_tdata  = {$urandom, $urandom};
         s_tkeep  = rnd[`PKT_DATA_BYTES-1:0];
         s_tlast  = (b == nbeats - 1);
         s_tuser  = rnd[15:8];
         t        = 0;
         took     = 1'b0;
         // ready for the current beat is settled by mid low phase.
         while (!took && t < WAIT_LIMIT) begin
            #(CLK_PERIOD / 4);
            took = s_tready;
            next_cycle();
            t++;
         end
         if (!took) begin
            $display("timeout: ingress beat %0d was never accepted", b);
            timeouts++;
            s_tvalid = 1'b0;
            return;
         end
      end
      s_tvalid = 1'b0;
      s_tlast  = 1'b0;
      gap = $urandom_range(3, 0);
      repeat (gap) next_cycle();
   endtask

   task automatic wb_access(input logic we, input logic [`WB_ADR_WID-1:0] adr,
                            input logic [`WB_DAT_WID-1:0] wdat);
      int t;
      logic got_ack;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      t        = 0;
      got_ack  = 1'b0;
      while (!got_ack && t < WAIT_LIMIT) begin
         next_cycle();
         got_ack = wb_ack;
         t++;
      end
      if (!got_ack) begin
         $display("timeout: no wishbone ack for address %h", adr);
         timeouts++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_counters();
      wb_access(1'b0, DROP_PKTS, '0);
      wb_access(1'b0, DROP_BYTES, '0);
   endtask

   initial begin
      int t;
      void'($urandom(32'hd031_ad68));
      timeouts  = 0;
      drop_pct  = 0;
      ready_pct = 100;
      rst       = 1'b1;
      s_tvalid  = 1'b0;
      s_tdata   = '0;
      s_tkeep   = '0;
      s_tlast   = 1'b0;
      s_tuser   = '0;
      m_tready  = 1'b1;
      drop_pkt  = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      repeat (4) @(negedge axi4s_in);
      rst = 1'b0;

      // ----------------------------------------
      // traffic phases
      // ----------------------------------------
      // plain forwarding with nothing dropped.
      repeat (20) send_packet();
      read_counters();

      // drop pulses with the sink always ready.
      drop_pct = 20;
      repeat (30) send_packet();
      read_counters();

      // drop pulses under back-pressure.
      ready_pct = 50;
      repeat (40) send_packet();
      read_counters();

      // clear both counters and read them back as zero.
      drop_pct = 0;
      wb_access(1'b1, DROP_CTRL, 'h1);
      read_counters();
      drop_pct = 20;
      repeat (20) send_packet();
      read_counters();
      wb_access(1'b0, 4'hc, '0);

      // drain what is still in flight.
      drop_pct  = 0;
      ready_pct = 100;
      t = 0;
      while (pending != 0 && t < WAIT_LIMIT) begin
         next_cycle();
         t++;
      end
      if (pending != 0) begin
         $display("timeout: %0d expected beats never left the egress port", pending);
         timeouts++;
      end

      total = stream_errs + reg_errs + DUT.u_sva.fail_count + timeouts;
      $display("error counts: stream %0d, register %0d, assertion %0d, timeout %0d",
               stream_errs, reg_errs, DUT.u_sva.fail_count, timeouts);
      if (total == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== verilog/axis_drop.sv ====
/*
 * packet drop stage.
 * discards the rest of the current packet once drop_pkt is seen,
 * forwards other beats through an output pipe and counts drops.
 */

`timescale 1ns/1ps

`include "pkt_drop_config.svh"

module axis_drop
   import axis_pkg::*;
#(
   parameter axis_pipe_mode_t OUT_PIPE_MODE = PULL
) (
   input  logic                   axi4s_in,
   input  logic                   rst,

   input  logic                   s_tvalid,
   output logic                   s_tready,
   input  axis_data_t             s_tdata,
   input  axis_keep_t             s_tkeep,
   input  logic                   s_tlast,
   input  axis_user_t             s_tuser,

   output logic                   m_tvalid,
   input  logic                   m_tready,
   output axis_data_t             m_tdata,
   output axis_keep_t             m_tkeep,
   output logic                   m_tlast,
   output axis_user_t             m_tuser,

   input  logic                   drop_pkt,

   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [`WB_ADR_WID-1:0] wb_adr,
   input  logic [`WB_DAT_WID-1:0] wb_dat_w,
   output logic [`WB_DAT_WID-1:0] wb_dat_r,
   output logic                   wb_ack
);

   logic drop_latch;
   logic drop;
   logic s_xfer;
   logic pipe_tvalid;
   logic pipe_tready;

   assign s_xfer = s_tvalid && s_tready;

   // held until the packet's last beat is taken, end of packet wins.
   always_ff @(posedge axi4s_in) begin
      if (rst) begin
         drop_latch <= 1'b0;
      end else if (s_xfer && s_tlast) begin
         drop_latch <= 1'b0;
      end else if (drop_pkt) begin
         drop_latch <= 1'b1;
      end
   end

   assign drop = drop_pkt || drop_latch;

   // ----------------------------------------
   // steering
   // ----------------------------------------
   // dropped beats are always accepted and never reach the pipe.
   assign s_tready    = pipe_tready || drop;
   assign pipe_tvalid = s_tvalid && !drop;

   axis_out_pipe #(.MODE(OUT_PIPE_MODE)) u_out_pipe (
      .axi4s_in   (axi4s_in),
      .rst        (rst),
      .in_tvalid  (pipe_tvalid),
      .in_tready  (pipe_tready),
      .in_tdata   (s_tdata),
      .in_tkeep   (s_tkeep),
      .in_tlast   (s_tlast),
      .in_tuser   (s_tuser),
      .out_tvalid (m_tvalid),
      .out_tready (m_tready),
      .out_tdata  (m_tdata),
      .out_tkeep  (m_tkeep),
      .out_tlast  (m_tlast),
      .out_tuser  (m_tuser)
   );

   axis_probe u_probe (
      .axi4s_in  (axi4s_in),
      .rst       (rst),
      .beat_drop (s_xfer && drop),
      .beat_keep (s_tkeep),
      .beat_last (s_tlast),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack)
   );

endmodule

// ==== verilog/axis_out_pipe.sv ====
/*
 * single registered stream stage.
 * PUSH form holds one beat, PULL form adds a skid entry so that
 * input ready is driven from a flop.
 */

`timescale 1ns/1ps

`include "pkt_drop_config.svh"

module axis_out_pipe
   import axis_pkg::*;
#(
   parameter axis_pipe_mode_t MODE = PULL
) (
   input  logic       axi4s_in,
   input  logic       rst,

   input  logic       in_tvalid,
   output logic       in_tready,
   input  axis_data_t in_tdata,
   input  axis_keep_t in_tkeep,
   input  logic       in_tlast,
   input  axis_user_t in_tuser,

   output logic       out_tvalid,
   input  logic       out_tready,
   output axis_data_t out_tdata,
   output axis_keep_t out_tkeep,
   output logic       out_tlast,
   output axis_user_t out_tuser
);

   logic in_xfer;
   logic load_out;

   assign in_xfer  = in_tvalid && in_tready;
   // output register is free or its beat leaves this cycle.
   assign load_out = !out_tvalid || out_tready;

   generate
      if (MODE == PUSH) begin : g_push

         assign in_tready = load_out;

         always_ff @(posedge axi4s_in) begin
            if (rst) begin
               out_tvalid <= 1'b0;
            end else if (load_out) begin
               out_tvalid <= in_tvalid;
            end
         end

         always_ff @(posedge axi4s_in) begin
            if (in_xfer) begin
               out_tdata <= in_tdata;
               out_tkeep <= in_tkeep;
               out_tlast <= in_tlast;
               out_tuser <= in_tuser;
            end
         end

      end else begin : g_pull

         logic       skid_vld;
         axis_data_t skid_tdata;
         axis_keep_t skid_tkeep;
         logic       skid_tlast;
         axis_user_t skid_tuser;

         // ready is low only while the skid entry holds a beat.
         assign in_tready = !skid_vld;

         always_ff @(posedge axi4s_in) begin
            if (rst) begin
               out_tvalid <= 1'b0;
               skid_vld   <= 1'b0;
            end else if (load_out) begin
               out_tvalid <= skid_vld || in_xfer;
               skid_vld   <= 1'b0;
            end else if (in_xfer) begin
               skid_vld <= 1'b1;
            end
         end

         // skid beat is older, so it goes out first.
         always_ff @(posedge axi4s_in) begin
            if (load_out) begin
               if (skid_vld) begin
                  out_tdata <= skid_tdata;
                  out_tkeep <= skid_tkeep;
                  out_tlast <= skid_tlast;
                  out_tuser <= skid_tuser;
               end else if (in_xfer) begin
                  out_tdata <= in_tdata;
                  out_tkeep <= in_tkeep;
                  out_tlast <= in_tlast;
                  out_tuser <= in_tuser;
               end
            end else if (in_xfer) begin
               skid_tdata <= in_tdata;
               skid_tkeep <= in_tkeep;
               skid_tlast <= in_tlast;
               skid_tuser <= in_tuser;
            end
         end

      end
   endgenerate

endmodule

// ==== verilog/axis_pkg.sv ====
/*
 * stream-side types for the packet drop stage.
 * payload field types and the output pipe mode.
 */

`include "pkt_drop_config.svh"

package axis_pkg;

   // ----------------------------------------
   // beat payload fields
   // ----------------------------------------
   typedef logic [`PKT_DATA_BYTES*8-1:0] axis_data_t;
   typedef logic [`PKT_DATA_BYTES-1:0]   axis_keep_t;

   // single sideband byte in place of tid/tdest.
   typedef logic [7:0] axis_user_t;

   // PUSH registers valid and data with ready passed through.
   // PULL is a skid buffer, ready comes from a flop too.
   typedef enum logic {
      PUSH,
      PULL
   } axis_pipe_mode_t;

endpackage

// ==== verilog/axis_probe.sv ====
/*
 * drop statistics probe.
 * counts dropped packets and dropped bytes, and serves both counters
 * on a Wishbone classic slave port with a clear control bit.
 */

`timescale 1ns/1ps

`include "pkt_drop_config.svh"

module axis_probe
   import axis_pkg::*;
   import csr_pkg::*;
(
   input  logic                   axi4s_in,
   input  logic                   rst,

   input  logic                   beat_drop,
   input  axis_keep_t             beat_keep,
   input  logic                   beat_last,

   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [`WB_ADR_WID-1:0] wb_adr,
   input  wb_data_t               wb_dat_w,
   output wb_data_t               wb_dat_r,
   output logic                   wb_ack
);

   wb_state_t state;
   csr_cnt_t  drop_pkts;
   csr_cnt_t  drop_bytes;
   csr_addr_t req_addr;
   logic      req;
   logic      clr;

   // number of valid byte lanes in a beat.
   function automatic csr_cnt_t keep_bytes(input axis_keep_t keep);
      csr_cnt_t n;
      n = '0;
      for (int i = 0; i < `PKT_DATA_BYTES; i++) begin
         n = n + csr_cnt_t'(keep[i]);
      end
      return n;
   endfunction

   // ----------------------------------------
   // bus handshake
   // ----------------------------------------
   assign req_addr = csr_addr_t'(wb_adr);
   assign req      = (state == WB_IDLE) && wb_cyc && wb_stb;
   assign clr      = req && wb_we && (req_addr == DROP_CTRL) && wb_dat_w[0];
   assign wb_ack   = (state == WB_ACK);

   // single cycle ack, then back to idle.
   always_ff @(posedge axi4s_in) begin
      if (rst) begin
         state <= WB_IDLE;
      end else if (req) begin
         state <= WB_ACK;
      end else begin
         state <= WB_IDLE;
      end
   end

   // read data sampled at the request edge, unknown offsets read zero.
   always_ff @(posedge axi4s_in) begin
      if (req) begin
         case (req_addr)
            DROP_PKTS:  wb_dat_r <= wb_data_t'(drop_pkts);
            DROP_BYTES: wb_dat_r <= wb_data_t'(drop_bytes);
            default:    wb_dat_r <= '0;
         endcase
      end
   end

   // ----------------------------------------
   // counters
   // ----------------------------------------
   // a clear wins over a dropped beat in the same cycle.
   always_ff @(posedge axi4s_in) begin
      if (rst || clr) begin
         drop_pkts  <= '0;
         drop_bytes <= '0;
      end else if (beat_drop) begin
         drop_bytes <= drop_bytes + keep_bytes(beat_keep);
         if (beat_last) begin
            drop_pkts <= drop_pkts + 1'b1;
         end
      end
   end

endmodule

// ==== verilog/csr_pkg.sv ====
/*
 * register-side types for the drop statistics probe.
 * counter and bus data types, register map and bus FSM states.
 */

`include "pkt_drop_config.svh"

package csr_pkg;

   typedef logic [`PKT_CNT_WID-1:0] csr_cnt_t;
   typedef logic [`WB_DAT_WID-1:0]  wb_data_t;

   // ----------------------------------------
   // register map, byte offsets
   // ----------------------------------------
   typedef enum logic [`WB_ADR_WID-1:0] {
      DROP_PKTS  = 'h0,
      DROP_BYTES = 'h4,
      DROP_CTRL  = 'h8
   } csr_addr_t;

   // bus handshake states.
   typedef enum logic {
      WB_IDLE,
      WB_ACK
   } wb_state_t;

endpackage

// ==== verilog/pkt_drop_config.svh ====
/*
 * packet drop stage build constants.
 * stream lane count, statistics counter width and Wishbone bus widths.
 */

`ifndef PKT_DROP_CONFIG_SVH
`define PKT_DROP_CONFIG_SVH

// number of byte lanes on the stream.
`define PKT_DATA_BYTES 8

// width of each statistics counter.
`define PKT_CNT_WID 32

// Wishbone byte address and data widths.
`define WB_ADR_WID 4
`define WB_DAT_WID 32

`endif

// ==== verilog/pkt_drop_top.sv ====
/*
 * packet drop subsystem top level.
 * drop stage built with a skid buffer on the egress side.
 */

`timescale 1ns/1ps

`include "pkt_drop_config.svh"

module pkt_drop_top
   import axis_pkg::*;
(
   input  logic                   axi4s_in,
   input  logic                   rst,

   input  logic                   s_tvalid,
   output logic                   s_tready,
   input  axis_data_t             s_tdata,
   input  axis_keep_t             s_tkeep,
   input  logic                   s_tlast,
   input  axis_user_t             s_tuser,

   output logic                   m_tvalid,
   input  logic                   m_tready,
   output axis_data_t             m_tdata,
   output axis_keep_t             m_tkeep,
   output logic                   m_tlast,
   output axis_user_t             m_tuser,

   input  logic                   drop_pkt,

   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [`WB_ADR_WID-1:0] wb_adr,
   input  logic [`WB_DAT_WID-1:0] wb_dat_w,
   output logic [`WB_DAT_WID-1:0] wb_dat_r,
   output logic                   wb_ack
);

   // registered ready toward the sender.
   axis_drop #(.OUT_PIPE_MODE(PULL)) u_drop (
      .axi4s_in (axi4s_in),
      .rst      (rst),
      .s_tvalid (s_tvalid),
      .s_tready (s_tready),
      .s_tdata  (s_tdata),
      .s_tkeep  (s_tkeep),
      .s_tlast  (s_tlast),
      .s_tuser  (s_tuser),
      .m_tvalid (m_tvalid),
      .m_tready (m_tready),
      .m_tdata  (m_tdata),
      .m_tkeep  (m_tkeep),
      .m_tlast  (m_tlast),
      .m_tuser  (m_tuser),
      .drop_pkt (drop_pkt),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

endmodule
